//--- files.f
verilog/osd_pkg.sv
verilog/osd_dip_if.sv
verilog/osd_status_rx.sv
verilog/osd_dip_decode.sv
verilog/osd_frame_apply.sv
verilog/osd_settings_top.sv
dv/osd_settings_chk.sv
dv/osd_settings_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f files.f --top-module osd_settings_tb \
    && ./obj_dir/Vosd_settings_tb | tee /dev/stderr | grep -q '^Verification passed$' \
    && echo "run ok" \
    || { echo "run failed"; exit 1; }

//--- dv/osd_settings_tb.sv
module osd_settings_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NROWS      = 10;
    localparam int MAX_CYCLES = NROWS * 60 + 200;  // a row needs about 30

    typedef struct packed {
        logic [31:0] word;    // status word sent lsb first
        logic [7:0]  opcode;
        logic [2:0]  nbytes;  // below 4 = cut short
        logic        mod0;
        logic        gpause;
    } row_t;

    logic       clk;
    logic       rst_n;
    logic       io_start;
    logic       io_strobe;
    logic [7:0] io_byte;
    logic       core_mod0;
    logic       game_pause;
    logic       vblank;
    logic [7:0] hdmi_arx;
    logic [7:0] hdmi_ary;
    logic [1:0] rotate;
    logic [2:0] scanlines;
    logic       en_mixing;
    logic [1:0] dip_fxlevel;
    logic       dip_pause;
    logic       enable_fm;
    logic       enable_psg;
    logic       dip_test;
    logic       dip_flip;
    logic       osd_pause;

    row_t        rows [NROWS];
    logic [15:0] lfsr;
    logic [31:0] exp_status;  // last word fully accepted
    logic [23:0] m_video;     // model {arx, ary, rotate, scanlines, mixing, fx}
    logic [23:0] c_video;     // committed at the last vblank
    logic [5:0]  m_imm;       // {pause, fm, psg, test, flip, osd_pause}
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    osd_settings_top UUT (.*);

    always #4 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout, test did not finish within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic check(input string tag, input string name,
                         input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch %s (%s): expected %0h, got %0h", name, tag, exp, act);
        end
    endtask

    // expected outputs from the accepted word and the core inputs
    task automatic predict();
        logic [31:0] s;
        logic        tate;
        logic [15:0] aspect;
        s      = exp_status;
        tate   = core_mod0 & ~s[osd_pkg::BIT_NOROT];
        aspect = s[osd_pkg::BIT_WIDE] ? {8'd16, 8'd9} : (tate ? {8'd3, 8'd4} : {8'd4, 8'd3});
        m_video = {aspect, s[osd_pkg::BIT_FLIP], tate,
                   s[osd_pkg::BIT_SCAN_LO +: 3], ~s[osd_pkg::BIT_SCAN_LO],
                   2'b10 ^ s[osd_pkg::BIT_FX_LO +: 2]};
        m_imm = {~(s[osd_pkg::BIT_PAUSE] | game_pause), ~s[osd_pkg::BIT_FM_OFF],
                 ~s[osd_pkg::BIT_PSG_OFF], ~s[osd_pkg::BIT_TEST], s[osd_pkg::BIT_FLIP],
                 s[osd_pkg::BIT_PAUSE]};
    endtask

    task automatic check_video(input string tag, input logic [23:0] v);
        check(tag, "hdmi_arx", 32'(v[23:16]), 32'(hdmi_arx));
        check(tag, "hdmi_ary", 32'(v[15:8]), 32'(hdmi_ary));
        check(tag, "rotate", 32'(v[7:6]), 32'(rotate));
        check(tag, "scanlines", 32'(v[5:3]), 32'(scanlines));
        check(tag, "en_mixing", 32'(v[2]), 32'(en_mixing));
        check(tag, "dip_fxlevel", 32'(v[1:0]), 32'(dip_fxlevel));
    endtask

    task automatic check_imm(input string tag, input logic [5:0] v);
        check(tag, "dip_pause", 32'(v[5]), 32'(dip_pause));
        check(tag, "enable_fm", 32'(v[4]), 32'(enable_fm));
        check(tag, "enable_psg", 32'(v[3]), 32'(enable_psg));
        check(tag, "dip_test", 32'(v[2]), 32'(dip_test));
        check(tag, "dip_flip", 32'(v[1]), 32'(dip_flip));
        check(tag, "osd_pause", 32'(v[0]), 32'(osd_pause));
    endtask

    // 0..3 idle cycles first, then one byte for one cycle
    task automatic send_byte(input logic start, input logic [7:0] b);
        int n;
        n = 0;
        repeat (2) begin
            n = n * 2 + int'(lfsr[0]);  // one step per bit
            lfsr = lfsr_step(lfsr);
        end
        repeat (n) @(negedge clk);
        io_start  = start;
        io_strobe = 1'b1;
        io_byte   = b;
        @(negedge clk);
        io_start  = 1'b0;
        io_strobe = 1'b0;
    endtask

    initial begin
        row_t  r;
        string tag;
        clk        = 1'b0;
        rst_n      = 1'b0;
        io_start   = 1'b0;
        io_strobe  = 1'b0;
        io_byte    = 8'h00;
        core_mod0  = 1'b0;
        game_pause = 1'b0;
        vblank     = 1'b0;
        lfsr       = 16'd48254;
        exp_status = 32'h0;
        // word, opcode, bytes sent, core_mod0, game_pause
        rows[0] = '{32'h1234_0848, 8'h1E, 3'd4, 1'b0, 1'b0};  // wide, fx, mixing off
        rows[1] = '{32'h0000_0000, 8'h1E, 3'd4, 1'b1, 1'b0};  // vertical game
        rows[2] = '{32'h0000_0004, 8'h1E, 3'd4, 1'b1, 1'b0};  // no rotation
        rows[3] = '{32'hFFFF_1302, 8'h1E, 3'd4, 1'b1, 1'b1};  // pause, channels off, flip
        rows[4] = '{32'h0000_FFFF, 8'h55, 3'd4, 1'b0, 1'b0};  // foreign opcode
        rows[5] = '{32'h0000_0FFF, 8'h1E, 3'd2, 1'b0, 1'b0};  // truncated
        rows[6] = '{32'hDEAD_0438, 8'h1E, 3'd4, 1'b0, 1'b1};  // test mode, scanlines 7
        rows[7] = '{32'h0000_0000, 8'h00, 3'd4, 1'b1, 1'b0};  // nop, tate from old word
        rows[8] = '{32'h0000_1080, 8'h1E, 3'd3, 1'b0, 1'b0};  // truncated
        rows[9] = '{32'h0000_00C2, 8'h1E, 3'd4, 1'b1, 1'b0};  // fx 3, flip plus tate
        repeat (5) @(negedge clk);
        // still in reset, registers hold their reset values
        c_video = {8'd4, 8'd3, 2'b00, 3'd0, 1'b1, 2'b10};  // after reset values
        check_video("reset", c_video);
        check_imm("reset", 6'b111100);
        rst_n = 1'b1;
        @(negedge clk);
        for (int i = 0; i < NROWS; i++) begin
            r   = rows[i];
            tag = $sformatf("row %0d", i);
            core_mod0  = r.mod0;
            game_pause = r.gpause;
            send_byte(1'b1, r.opcode);
            for (int k = 0; k < int'(r.nbytes); k++) begin
                send_byte(1'b0, r.word[8*k +: 8]);
            end
            if (r.nbytes != 3'd4) begin
                send_byte(1'b1, 8'h00);  // new opcode cuts the command
            end else if (r.opcode == 8'h1E) begin
                exp_status = r.word;
            end
            @(negedge clk);  // second cycle after the last byte
            predict();
            check_imm(tag, m_imm);
            check_video(tag, c_video);  // no vblank yet
            vblank = 1'b1;
            @(negedge clk);
            check_video(tag, m_video);
            c_video = m_video;
            vblank  = 1'b0;
            // game pause merge, one cycle each way
            repeat (2) begin
                game_pause = ~game_pause;
                @(negedge clk);
                predict();
                check(tag, "dip_pause", 32'(m_imm[5]), 32'(dip_pause));
            end
        end
        errors += UUT.u_rx.chk_i.fails;  // bound assertions count too
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- dv/osd_settings_chk.sv
module osd_settings_chk (
    input logic               clk,
    input logic               rst_n,
    input logic               io_strobe,
    input logic [31:0]        status,
    input osd_pkg::rx_state_e state,
    input logic [1:0]         byte_cnt
);

    timeunit 1ns;
    timeprecision 1ps;

    int fails = 0;  // failed assertions so far

    // the word only moves on the edge that took a byte
    status_needs_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(status) |-> $past(io_strobe))
        else begin
            $error("status changed without a byte strobe");
            fails++;
        end

    // FSM leaves reset idle
    idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> state == osd_pkg::RX_IDLE)
        else begin
            $error("receiver not idle after reset");
            fails++;
        end

    // counter only runs while collecting bytes, back to zero otherwise
    byte_cnt_clear: assert property (@(posedge clk) disable iff (!rst_n)
        state != osd_pkg::RX_LOAD |-> byte_cnt == 2'd0)
        else begin
            $error("byte counter left running outside a status load");
            fails++;
        end

endmodule

bind osd_status_rx osd_settings_chk chk_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .io_strobe (io_strobe),
    .status    (status),
    .state     (state),
    .byte_cnt  (byte_cnt)
);

//--- verilog/osd_settings_top.sv
module osd_settings_top #(
    parameter logic [7:0] ARX          = 8'd4,
    parameter logic [7:0] ARY          = 8'd3,
    parameter bit         VERTICAL     = 1'b1,
    parameter bit         CHANNEL_CTRL = 1'b1
) (
    input  logic       clk,
    input  logic       rst_n,
    // I/O controller byte interface
    input  logic       io_start,
    input  logic       io_strobe,
    input  logic [7:0] io_byte,
    // from the game core
    input  logic       core_mod0,
    input  logic       game_pause,
    input  logic       vblank,
    // video, frame synchronous
    output logic [7:0] hdmi_arx,
    output logic [7:0] hdmi_ary,
    output logic [1:0] rotate,
    output logic [2:0] scanlines,
    output logic       en_mixing,
    output logic [1:0] dip_fxlevel,
    // immediate
    output logic       dip_pause,
    output logic       enable_fm,
    output logic       enable_psg,
    output logic       dip_test,
    output logic       dip_flip,
    output logic       osd_pause
);

    logic [osd_pkg::STATUS_W-1:0] status;  // assembled menu word

    osd_dip_if video_bus ();  // decoder to frame apply

    osd_status_rx u_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .io_start  (io_start),
        .io_strobe (io_strobe),
        .io_byte   (io_byte),
        .status    (status)
    );

    osd_dip_decode #(
        .ARX          (ARX),
        .ARY          (ARY),
        .VERTICAL     (VERTICAL),
        .CHANNEL_CTRL (CHANNEL_CTRL)
    ) u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .status     (status),
        .core_mod0  (core_mod0),
        .game_pause (game_pause),
        .video      (video_bus.src),
        .dip_pause  (dip_pause),
        .enable_fm  (enable_fm),
        .enable_psg (enable_psg),
        .dip_test   (dip_test),
        .dip_flip   (dip_flip),
        .osd_pause  (osd_pause)
    );

    osd_frame_apply #(
        .ARX (ARX),
        .ARY (ARY)
    ) u_apply (
        .clk         (clk),
        .rst_n       (rst_n),
        .vblank      (vblank),
        .pend        (video_bus.dst),
        .hdmi_arx    (hdmi_arx),
        .hdmi_ary    (hdmi_ary),
        .rotate      (rotate),
        .scanlines   (scanlines),
        .en_mixing   (en_mixing),
        .dip_fxlevel (dip_fxlevel)
    );

endmodule

//--- verilog/osd_frame_apply.sv
module osd_frame_apply #(
    parameter logic [7:0] ARX = 8'd4,  // reset aspect, same as decoder
    parameter logic [7:0] ARY = 8'd3
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       vblank,
    osd_dip_if.dst     pend,          // pending settings from decoder
    output logic [7:0] hdmi_arx,
    output logic [7:0] hdmi_ary,
    output logic [1:0] rotate,
    output logic [2:0] scanlines,
    output logic       en_mixing,
    output logic [1:0] dip_fxlevel
);

    logic vblank_q;   // previous vblank
    logic vb_rise;    // start of vertical blank

    assign vb_rise = vblank & ~vblank_q;

    // starts high so a vblank held through reset is not taken as an edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vblank_q <= 1'b1;
        end else begin
            vblank_q <= vblank;
        end
    end

    // whole set moves at once, never mid frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdmi_arx    <= ARX;
            hdmi_ary    <= ARY;
            rotate      <= 2'b00;
            scanlines   <= 3'd0;
            en_mixing   <= 1'b1;
            dip_fxlevel <= osd_pkg::FX_DEFAULT;
        end else if (vb_rise) begin
            hdmi_arx    <= pend.hdmi_arx;
            hdmi_ary    <= pend.hdmi_ary;
            rotate      <= pend.rotate;
            scanlines   <= pend.scanlines;
            en_mixing   <= pend.en_mixing;
            dip_fxlevel <= pend.dip_fxlevel;
        end
    end

endmodule

//--- verilog/osd_dip_decode.sv
module osd_dip_decode #(
    parameter logic [7:0] ARX          = 8'd4,  // native aspect
    parameter logic [7:0] ARY          = 8'd3,
    parameter bit         VERTICAL     = 1'b1,  // core may run vertical games
    parameter bit         CHANNEL_CTRL = 1'b1   // menu controls fm/psg
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [osd_pkg::STATUS_W-1:0] status,
    input  logic                         core_mod0,   // game is vertical
    input  logic                         game_pause,  // pause from the game itself
    osd_dip_if.src                       video,
    output logic                         dip_pause,   // active low
    output logic                         enable_fm,
    output logic                         enable_psg,
    output logic                         dip_test,    // active low
    output logic                         dip_flip,
    output logic                         osd_pause
);

    logic tate;   // screen shown rotated
    logic wide;
    logic flip;

    assign tate = VERTICAL && core_mod0 && !status[osd_pkg::BIT_NOROT];
    assign wide = status[osd_pkg::BIT_WIDE];
    assign flip = status[osd_pkg::BIT_FLIP];

    // video bundle, picked up later by the frame apply stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            video.hdmi_arx    <= ARX;
            video.hdmi_ary    <= ARY;
            video.rotate      <= 2'b00;
            video.scanlines   <= 3'd0;
            video.en_mixing   <= 1'b1;
            video.dip_fxlevel <= osd_pkg::FX_DEFAULT;
        end else begin
            if (wide) begin
                video.hdmi_arx <= 8'd16;
                video.hdmi_ary <= 8'd9;
            end else if (tate) begin
                video.hdmi_arx <= ARY;  // swapped for vertical
                video.hdmi_ary <= ARX;
            end else begin
                video.hdmi_arx <= ARX;
                video.hdmi_ary <= ARY;
            end
            video.rotate      <= {flip, tate};
            video.scanlines   <= status[osd_pkg::BIT_SCAN_LO +: 3];
            video.en_mixing   <= ~status[osd_pkg::BIT_SCAN_LO];  // filter on when clear
            video.dip_fxlevel <= osd_pkg::FX_DEFAULT ^ status[osd_pkg::BIT_FX_LO +: 2];
        end
    end

    // immediate controls, no frame sync
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dip_pause  <= 1'b1;  // running
            enable_fm  <= 1'b1;
            enable_psg <= 1'b1;
            dip_test   <= 1'b1;
            dip_flip   <= 1'b0;
            osd_pause  <= 1'b0;
        end else begin
            // either source can pause, dip is active low
            dip_pause  <= ~(status[osd_pkg::BIT_PAUSE] | game_pause);
            enable_fm  <= ~status[osd_pkg::BIT_FM_OFF] | !CHANNEL_CTRL;
            enable_psg <= ~status[osd_pkg::BIT_PSG_OFF] | !CHANNEL_CTRL;
            dip_test   <= ~status[osd_pkg::BIT_TEST];
            dip_flip   <= flip;
            osd_pause  <= status[osd_pkg::BIT_PAUSE];
        end
    end

endmodule

//--- verilog/osd_status_rx.sv
module osd_status_rx (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         io_start,   // opcode marker
    input  logic                         io_strobe,  // byte valid
    input  logic [7:0]                   io_byte,
    output logic [osd_pkg::STATUS_W-1:0] status      // last complete word
);

    osd_pkg::rx_state_e state;
    osd_pkg::osd_cmd_e  opcode;

    logic [1:0]                    byte_cnt;  // data bytes taken so far
    logic [osd_pkg::STATUS_W-9:0]  shadow;    // first three bytes
    logic                          opcode_byte;
    logic                          data_byte;
    logic                          load_byte;

    assign opcode      = osd_pkg::osd_cmd_e'(io_byte);
    assign opcode_byte = io_strobe & io_start;   // restarts any command
    assign data_byte   = io_strobe & ~io_start;
    assign load_byte   = data_byte && (state == osd_pkg::RX_LOAD);

    // control path
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= osd_pkg::RX_IDLE;
            byte_cnt <= 2'd0;
            status   <= '0;
        end else if (opcode_byte) begin
            byte_cnt <= 2'd0;
            case (opcode)
                osd_pkg::CMD_STATUS_SET: state <= osd_pkg::RX_LOAD;
                default:                 state <= osd_pkg::RX_SKIP;  // NOP and unknown
            endcase
        end else if (load_byte) begin
            byte_cnt <= byte_cnt + 2'd1;
            if (byte_cnt == 2'd3) begin
                // fourth byte completes the word
                status <= {io_byte, shadow};
                state  <= osd_pkg::RX_IDLE;
            end
        end
    end

    // lsb first, so each new byte enters at the top
    always_ff @(posedge clk) begin
        if (load_byte) begin
            shadow <= {io_byte, shadow[osd_pkg::STATUS_W-9:8]};
        end
    end

    // a truncated command leaves status alone, shadow is simply refilled
    // on the next CMD_STATUS_SET since byte_cnt restarts at zero

endmodule

//--- verilog/osd_dip_if.sv
// video settings from the decoder, waiting for the next vblank
interface osd_dip_if;

    logic [7:0] hdmi_arx;     // aspect x
    logic [7:0] hdmi_ary;     // aspect y
    logic [1:0] rotate;       // {flip, tate}
    logic [2:0] scanlines;
    logic       en_mixing;    // screen filter
    logic [1:0] dip_fxlevel;

    // decoder side
    modport src (
        output hdmi_arx, hdmi_ary, rotate, scanlines, en_mixing, dip_fxlevel
    );

    // frame apply side
    modport dst (
        input hdmi_arx, hdmi_ary, rotate, scanlines, en_mixing, dip_fxlevel
    );

endinterface

//--- verilog/osd_pkg.sv
package osd_pkg;

    // opcodes sent by the I/O controller with io_start high
    typedef enum logic [7:0] {
        CMD_NOP        = 8'h00,  // ignored
        CMD_STATUS_SET = 8'h1E   // four status bytes follow, lsb first
    } osd_cmd_e;

    // status receiver FSM
    typedef enum logic [1:0] {
        RX_IDLE = 2'd0,  // waiting for an opcode
        RX_LOAD = 2'd1,  // collecting status bytes
        RX_SKIP = 2'd2   // foreign opcode, drop data until next start
    } rx_state_e;

    localparam int STATUS_W = 32;  // menu status word

    // bit positions inside the status word
    localparam int BIT_FLIP    = 1;   // screen flip
    localparam int BIT_NOROT   = 2;   // 1 = keep original orientation
    localparam int BIT_SCAN_LO = 3;   // scanline fx, 3 bits; bit 3 low = mixing on
    localparam int BIT_FX_LO   = 6;   // fx volume, 2 bits
    localparam int BIT_PSG_OFF = 8;
    localparam int BIT_FM_OFF  = 9;
    localparam int BIT_TEST    = 10;  // test mode
    localparam int BIT_WIDE    = 11;  // 16:9 output
    localparam int BIT_PAUSE   = 12;  // menu pause

    // menu value 0 maps to the "high" volume setting
    localparam logic [1:0] FX_DEFAULT = 2'b10;

endpackage
